/* logic/bram_stream_params.svh */
`ifndef BRAM_STREAM_PARAMS_SVH
`define BRAM_STREAM_PARAMS_SVH

// Sample width in bits
`define BS_DATA_W 16

// RAM address width giving a depth of 2**BS_ADDR_W
`define BS_ADDR_W 8

// Loop and repeat counter width
`define BS_ITER_W 8

`endif

/* logic/bram_stream_pkg.sv */
`default_nettype none

`include "bram_stream_params.svh"

package bram_stream_pkg;

  typedef logic [`BS_DATA_W-1:0] data_t;
  typedef logic [`BS_ADDR_W-1:0] addr_t;

  // One bit wider than addr_t so a full sweep fits
  typedef logic [`BS_ADDR_W:0]   count_t;
  typedef logic [`BS_ITER_W-1:0] iter_t;

  // Run sequencer states
  typedef enum logic [2:0] {
    G_IDLE,
    G_START,
    G_RUN,
    G_END,
    G_ERR
  } glo_state_t;

  // Read FSM states
  typedef enum logic [1:0] {
    L_IDLE,
    L_OPER,
    L_END,
    L_ERR
  } loc_state_t;

endpackage

`default_nettype wire

/* logic/axis_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface axis_if;

  bram_stream_pkg::data_t tdata;
  logic                   tvalid;
  logic                   tready;
  logic                   tlast;

  // Producer side
  modport src (output tdata, output tvalid, output tlast, input tready);

  // Consumer side
  modport snk (input tdata, input tvalid, input tlast, output tready);

endinterface

`default_nettype wire

/* logic/sample_bram.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bram_stream_params.svh"

module sample_bram (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          wr_en,
  input  wire bram_stream_pkg::addr_t  wr_addr,
  input  wire bram_stream_pkg::data_t  wr_data,
  input  wire                          rd_en,
  input  wire bram_stream_pkg::addr_t  rd_addr,
  output bram_stream_pkg::data_t       rd_data,
  output logic                         rd_ack
);

  localparam int DEPTH = 2 ** `BS_ADDR_W;

  bram_stream_pkg::data_t mem [0:DEPTH-1];

  // Load port write and registered read
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  // Acknowledge follows the read by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ack <= 1'b0;
    end else begin
      rd_ack <= rd_en;
    end
  end

endmodule

`default_nettype wire

/* logic/stream_skid_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module stream_skid_buffer (
  input  wire         clk,
  input  wire         rst,
  input  wire         flush,
  input  wire         pop_ready,
  output logic [1:0]  free_slots,
  axis_if.snk         in,
  axis_if.src         out
);

  bram_stream_pkg::data_t main_data;
  bram_stream_pkg::data_t skid_data;
  logic                   main_valid;
  logic                   main_last;
  logic                   skid_valid;
  logic                   skid_last;
  logic                   push;
  logic                   pop;

  // Ready comes from registered state only
  assign in.tready = !skid_valid;
  assign push      = in.tvalid && in.tready;

  // Head leaves only when the consumer takes its releasing beat
  assign pop = main_valid && out.tready && pop_ready;

  assign out.tdata  = main_data;
  assign out.tvalid = main_valid;
  assign out.tlast  = main_valid && main_last && pop_ready;

  assign free_slots = 2'd2 - {1'b0, main_valid} - {1'b0, skid_valid};

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (pop) begin
        main_valid <= skid_valid || push;
      end else if (push) begin
        main_valid <= 1'b1;
      end

      if (skid_valid) begin
        skid_valid <= !pop;
      end else begin
        skid_valid <= push && main_valid && !pop;
      end
    end
  end

  // Payload moves between the two entries
  always_ff @(posedge clk) begin
    if (skid_valid) begin
      if (pop) begin
        main_data <= skid_data;
        main_last <= skid_last;
      end
    end else if (push) begin
      if (!main_valid || pop) begin
        main_data <= in.tdata;
        main_last <= in.tlast;
      end else begin
        // Park the beat while the output stalls
        skid_data <= in.tdata;
        skid_last <= in.tlast;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/bram_read_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module bram_read_fsm (
  input  wire                              clk,
  input  wire                              rst,
  input  wire bram_stream_pkg::glo_state_t glo_state,
  input  wire bram_stream_pkg::count_t     word_max,
  input  wire bram_stream_pkg::iter_t      loop_max,
  input  wire bram_stream_pkg::iter_t      rep_max,
  output logic                             rd_en,
  output bram_stream_pkg::addr_t           rd_addr,
  input  wire bram_stream_pkg::data_t      rd_data,
  input  wire                              rd_ack,
  input  wire [1:0]                        free_slots,
  axis_if.src                              rd_stream,
  axis_if.snk                              out_stream,
  output logic                             pop_ready,
  output logic                             flush,
  output logic                             run_done,
  output logic                             run_error
);

  bram_stream_pkg::loc_state_t state_q;
  bram_stream_pkg::addr_t      addr_q;
  bram_stream_pkg::iter_t      loop_q;
  bram_stream_pkg::iter_t      rep_q;
  logic                        last_q;
  logic                        zero_count;
  logic                        last_addr;
  logic                        last_loop;
  logic                        last_rep;
  logic                        room;
  logic                        beat;

  assign zero_count = (word_max == '0) || (loop_max == '0) || (rep_max == '0);
  assign last_addr  = ({1'b0, addr_q} == word_max - 1'b1);
  assign last_loop  = (loop_q == loop_max - 1'b1);

  // A returning word already claims one of the free entries
  assign room = rd_ack ? (free_slots == 2'd2) : rd_stream.tready;

  assign rd_en   = (state_q == bram_stream_pkg::L_OPER) && room;
  assign rd_addr = addr_q;

  // RAM output feeds the buffer directly
  assign rd_stream.tdata  = rd_data;
  assign rd_stream.tvalid = rd_ack;
  assign rd_stream.tlast  = last_q;

  // Repeat handling on the output side
  assign beat      = out_stream.tvalid && out_stream.tready;
  assign last_rep  = (rep_q == rep_max - 1'b1);
  assign pop_ready = last_rep;

  assign flush = (state_q == bram_stream_pkg::L_ERR);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= bram_stream_pkg::L_IDLE;
      addr_q    <= '0;
      loop_q    <= '0;
      last_q    <= 1'b0;
      run_done  <= 1'b0;
      run_error <= 1'b0;
    end else begin
      // Tag travels with the read and returns with the ack
      last_q    <= rd_en && last_addr && last_loop;
      run_done  <= 1'b0;
      run_error <= 1'b0;

      case (state_q)
        bram_stream_pkg::L_IDLE: begin
          addr_q <= '0;
          loop_q <= '0;
          if (glo_state == bram_stream_pkg::G_START) begin
            if (zero_count) begin
              state_q   <= bram_stream_pkg::L_ERR;
              run_error <= 1'b1;
            end else begin
              state_q <= bram_stream_pkg::L_OPER;
            end
          end
        end
        bram_stream_pkg::L_OPER: begin
          if (rd_en) begin
            if (last_addr) begin
              addr_q <= '0;
              if (last_loop) begin
                state_q <= bram_stream_pkg::L_END;
              end else begin
                loop_q <= loop_q + 1'b1;
              end
            end else begin
              addr_q <= addr_q + 1'b1;
            end
          end
        end
        bram_stream_pkg::L_END: begin
          // Wait for the final beat once all reads are issued
          if (beat && out_stream.tlast) begin
            run_done <= 1'b1;
          end
          if (glo_state == bram_stream_pkg::G_END) begin
            state_q <= bram_stream_pkg::L_IDLE;
          end
        end
        bram_stream_pkg::L_ERR: begin
          if (glo_state == bram_stream_pkg::G_ERR) begin
            state_q <= bram_stream_pkg::L_IDLE;
          end
        end
        default: begin
          state_q <= bram_stream_pkg::L_IDLE;
        end
      endcase
    end
  end

  // Counts beats of the word at the buffer head
  always_ff @(posedge clk) begin
    if (rst || (state_q == bram_stream_pkg::L_IDLE)) begin
      rep_q <= '0;
    end else if (beat) begin
      rep_q <= last_rep ? '0 : rep_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/run_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module run_sequencer (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          start,
  input  wire bram_stream_pkg::count_t word_count,
  input  wire bram_stream_pkg::iter_t  loop_count,
  input  wire bram_stream_pkg::iter_t  repeat_count,
  input  wire                          run_done,
  input  wire                          run_error,
  output bram_stream_pkg::glo_state_t  glo_state,
  output bram_stream_pkg::count_t      word_max,
  output bram_stream_pkg::iter_t       loop_max,
  output bram_stream_pkg::iter_t       rep_max,
  output logic                         busy,
  output logic                         done,
  output logic                         error
);

  always_ff @(posedge clk) begin
    if (rst) begin
      glo_state <= bram_stream_pkg::G_IDLE;
      busy      <= 1'b0;
      done      <= 1'b0;
      error     <= 1'b0;
    end else begin
      done  <= 1'b0;
      error <= 1'b0;

      case (glo_state)
        bram_stream_pkg::G_IDLE: begin
          if (start) begin
            glo_state <= bram_stream_pkg::G_START;
            busy      <= 1'b1;
          end
        end
        bram_stream_pkg::G_START: begin
          glo_state <= bram_stream_pkg::G_RUN;
        end
        bram_stream_pkg::G_RUN: begin
          if (run_error) begin
            glo_state <= bram_stream_pkg::G_ERR;
            busy      <= 1'b0;
            error     <= 1'b1;
          end else if (run_done) begin
            glo_state <= bram_stream_pkg::G_END;
            busy      <= 1'b0;
            done      <= 1'b1;
          end
        end
        default: begin
          // G_END and G_ERR last one cycle
          glo_state <= bram_stream_pkg::G_IDLE;
        end
      endcase
    end
  end

  // Counts held for the whole run
  always_ff @(posedge clk) begin
    if ((glo_state == bram_stream_pkg::G_IDLE) && start) begin
      word_max <= word_count;
      loop_max <= loop_count;
      rep_max  <= repeat_count;
    end
  end

endmodule

`default_nettype wire

/* logic/bram_stream_top.sv */
`timescale 1ns/1ns
`default_nettype none

module bram_stream_top (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          load_en,
  input  wire bram_stream_pkg::addr_t  load_addr,
  input  wire bram_stream_pkg::data_t  load_data,
  input  wire                          start,
  input  wire bram_stream_pkg::count_t word_count,
  input  wire bram_stream_pkg::iter_t  loop_count,
  input  wire bram_stream_pkg::iter_t  repeat_count,
  output bram_stream_pkg::data_t       m_tdata,
  output logic                         m_tvalid,
  input  wire                          m_tready,
  output logic                         m_tlast,
  output logic                         busy,
  output logic                         done,
  output logic                         error
);

  bram_stream_pkg::glo_state_t glo_state;
  bram_stream_pkg::count_t     word_max;
  bram_stream_pkg::iter_t      loop_max;
  bram_stream_pkg::iter_t      rep_max;
  bram_stream_pkg::addr_t      rd_addr;
  bram_stream_pkg::data_t      rd_data;
  logic                        rd_en;
  logic                        rd_ack;
  logic [1:0]                  free_slots;
  logic                        pop_ready;
  logic                        flush;
  logic                        run_done;
  logic                        run_error;

  axis_if rd_stream ();
  axis_if out_stream ();

  assign out_stream.tready = m_tready;
  assign m_tdata           = out_stream.tdata;
  assign m_tvalid          = out_stream.tvalid;
  assign m_tlast           = out_stream.tlast;

  sample_bram u_bram (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (load_en),
    .wr_addr (load_addr),
    .wr_data (load_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .rd_ack  (rd_ack)
  );

  bram_read_fsm u_read_fsm (
    .clk        (clk),
    .rst        (rst),
    .glo_state  (glo_state),
    .word_max   (word_max),
    .loop_max   (loop_max),
    .rep_max    (rep_max),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .rd_ack     (rd_ack),
    .free_slots (free_slots),
    .rd_stream  (rd_stream.src),
    .out_stream (out_stream.snk),
    .pop_ready  (pop_ready),
    .flush      (flush),
    .run_done   (run_done),
    .run_error  (run_error)
  );

  stream_skid_buffer u_skid (
    .clk        (clk),
    .rst        (rst),
    .flush      (flush),
    .pop_ready  (pop_ready),
    .free_slots (free_slots),
    .in         (rd_stream.snk),
    .out        (out_stream.src)
  );

  run_sequencer u_sequencer (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .word_count   (word_count),
    .loop_count   (loop_count),
    .repeat_count (repeat_count),
    .run_done     (run_done),
    .run_error    (run_error),
    .glo_state    (glo_state),
    .word_max     (word_max),
    .loop_max     (loop_max),
    .rep_max      (rep_max),
    .busy         (busy),
    .done         (done),
    .error        (error)
  );

endmodule

`default_nettype wire

/* bench/bram_stream_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module bram_stream_tb;

  localparam int NUM_RUNS = 15;
  localparam int DEPTH    = 256;

  logic clk, rst, load_en, start, m_tready;
  logic m_tvalid, m_tlast, busy, done, error;
  bram_stream_pkg::addr_t  load_addr;
  bram_stream_pkg::data_t  load_data;
  bram_stream_pkg::count_t word_count;
  bram_stream_pkg::iter_t  loop_count;
  bram_stream_pkg::iter_t  repeat_count;
  bram_stream_pkg::data_t  m_tdata;

  integer seed = 32'h65ec_ad21;
  bram_stream_pkg::data_t mem_model [0:DEPTH-1];
  bram_stream_pkg::data_t exp_data [$];
  logic                   exp_last [$];
  int   run_n [NUM_RUNS];
  int   run_l [NUM_RUNS];
  int   run_r [NUM_RUNS];
  logic run_bp [NUM_RUNS];
  int   cycle_count = 0;
  int   cycle_limit = 0;
  int   done_count = 0;
  int   error_count = 0;
  int   beat_count = 0;
  int   last_cycle = 0;
  logic in_run = 1'b0;
  logic last_done = 1'b0;
  logic stalled = 1'b0;
  logic held_last = 1'b0;
  bram_stream_pkg::data_t held_data = '0;

  bram_stream_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic end_with_failure();
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input bram_stream_pkg::data_t exp,
                            input bram_stream_pkg::data_t act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_last(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      end_with_failure();
    end
  endtask

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // Sweep of N words repeated L times with each word sent R times in a row
  task automatic build_expected(input int n, input int l, input int r);
    int p;
    int k;
    int j;
    exp_data.delete();
    exp_last.delete();
    for (p = 0; p < l; p++) begin
      for (k = 0; k < n; k++) begin
        for (j = 0; j < r; j++) begin
          exp_data.push_back(mem_model[k]);
          exp_last.push_back((p == l - 1) && (k == n - 1) && (j == r - 1));
        end
      end
    end
  endtask

  task automatic load_memory();
    int a;
    for (a = 0; a < DEPTH; a++) begin
      @(negedge clk);
      load_en   = 1'b1;
      load_addr = a;
      load_data = $random(seed);
      mem_model[a] = load_data;
    end
    @(negedge clk);
    load_en = 1'b0;
  endtask

  task automatic run_stream(input int idx);
    int n;
    int l;
    int r;
    int cyc;
    int done_before;
    int error_before;
    logic refused;
    n = run_n[idx];
    l = run_l[idx];
    r = run_r[idx];
    refused = (n == 0) || (l == 0) || (r == 0);
    build_expected(n, l, r);
    done_before  = done_count;
    error_before = error_count;
    beat_count   = 0;
    last_done    = 1'b0;
    @(negedge clk);
    word_count   = n;
    loop_count   = l;
    repeat_count = r;
    start        = 1'b1;
    @(negedge clk);
    in_run = 1'b1;
    cyc    = 0;
    while ((done_count == done_before) && (error_count == error_before)) begin
      // Extra start while busy and count inputs scrambled after latching
      start        = (cyc == 3) && busy;
      m_tready     = run_bp[idx] ? (rand_range(0, 9) >= 4) : 1'b1;
      word_count   = rand_range(0, 511);
      loop_count   = rand_range(0, 255);
      repeat_count = rand_range(0, 255);
      cyc++;
      @(negedge clk);
    end
    start    = 1'b0;
    m_tready = 1'b1;
    repeat (8) @(negedge clk);
    if ((done_count - done_before != (refused ? 0 : 1)) ||
        (error_count - error_before != (refused ? 1 : 0))) begin
      $display("Run %0d gave %0d done and %0d error pulses", idx,
               done_count - done_before, error_count - error_before);
      end_with_failure();
    end
    if (beat_count != n * l * r) begin
      $display("Run %0d sent %0d beats instead of %0d", idx, beat_count, n * l * r);
      end_with_failure();
    end
    check_flag("busy after run", 1'b0, busy);
  endtask

  // Output monitor sampling on the rising edge
  always @(posedge clk) begin
    if (!rst) begin
      if (stalled) begin
        check_flag("tvalid held in stall", 1'b1, m_tvalid);
        check_data("tdata held in stall", held_data, m_tdata);
        check_last("tlast held in stall", held_last, m_tlast);
      end
      if (m_tvalid && (exp_data.size() == 0)) begin
        $display("tvalid was raised while no beat was expected");
        end_with_failure();
      end else if (m_tvalid && m_tready) begin
        check_data($sformatf("beat %0d tdata", beat_count), exp_data[0], m_tdata);
        check_last($sformatf("beat %0d tlast", beat_count), exp_last[0], m_tlast);
        void'(exp_data.pop_front());
        void'(exp_last.pop_front());
        beat_count++;
        if (m_tlast) begin
          last_done  = 1'b1;
          last_cycle = cycle_count;
        end
      end
      if (done) begin
        if (!last_done || (cycle_count - last_cycle > 2)) begin
          $display("done did not follow the tlast transfer within two cycles");
          end_with_failure();
        end
        check_flag("busy with done", 1'b0, busy);
        done_count++;
        in_run = 1'b0;
      end
      if (error) begin
        check_flag("busy with error", 1'b0, busy);
        error_count++;
        in_run = 1'b0;
      end else if (in_run && !done) begin
        check_flag("busy during run", 1'b1, busy);
      end
      stalled   = m_tvalid && !m_tready;
      held_data = m_tdata;
      held_last = m_tlast;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, the runs did not complete", cycle_count);
      end_with_failure();
    end
  end

  initial begin
    int i;
    rst          = 1'b1;
    load_en      = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    start        = 1'b0;
    word_count   = '0;
    loop_count   = '0;
    repeat_count = '0;
    m_tready     = 1'b1;
    for (i = 0; i < NUM_RUNS; i++) begin
      run_n[i]  = rand_range(1, 48);
      run_l[i]  = rand_range(1, 4);
      run_r[i]  = rand_range(1, 4);
      run_bp[i] = (i >= 5);
    end
    // Full plain sweep first and one zero count in runs 9, 11 and 13
    run_n[0] = DEPTH;
    run_l[0] = 1;
    run_r[0] = 1;
    run_n[9]  = 0;
    run_l[11] = 0;
    run_r[13] = 0;
    // Reset and RAM load come ahead of the runs
    cycle_limit = 2 * DEPTH;
    for (i = 0; i < NUM_RUNS; i++) begin
      cycle_limit += 4 * run_n[i] * run_l[i] * run_r[i] + 50;
    end
    repeat (4) @(negedge clk);
    rst = 1'b0;
    check_flag("tvalid after reset", 1'b0, m_tvalid);
    check_flag("tlast after reset", 1'b0, m_tlast);
    check_flag("busy after reset", 1'b0, busy);
    check_flag("done after reset", 1'b0, done);
    check_flag("error after reset", 1'b0, error);
    check_flag("rd_en after reset", 1'b0, dut.rd_en);
    load_memory();
    for (i = 0; i < NUM_RUNS; i++) begin
      run_stream(i);
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* bram_stream.f */
+incdir+logic
logic/bram_stream_pkg.sv
logic/axis_if.sv
logic/sample_bram.sv
logic/stream_skid_buffer.sv
logic/bram_read_fsm.sv
logic/run_sequencer.sv
logic/bram_stream_top.sv
bench/bram_stream_tb.sv
